// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= Everything OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/apb_if.sv
// APB interface with requester and completer modports
`timescale 1ns/10ps

interface apb_if;

	// request, driven by the requester
	logic psel;
	logic penable;
	logic pwrite;
	soc_bus_pkg::paddr_t paddr;
	soc_bus_pkg::pdata_t pwdata;

	// response, valid in the access cycle with pready high
	soc_bus_pkg::pdata_t prdata;
	logic pready;
	logic pslverr;

	modport requester (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pready, pslverr
	);

	modport completer (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

// File: common/soc_bus_pkg.sv
// APB widths and word types, slave-select and offset fields, address map
package soc_bus_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] paddr_t;
	typedef logic [DATA_W-1:0] pdata_t;

	// --------------------
	// decode fields

	// slave select in the top address bits
	localparam int SEL_LSB = 14;
	localparam int SEL_MSB = 15;
	localparam int SEL_W = SEL_MSB - SEL_LSB + 1;

	typedef logic [SEL_W-1:0] sel_t;

	// register offset, everything below the select field
	localparam int OFS_W = SEL_LSB;

	typedef logic [OFS_W-1:0] pofs_t;

	// address map, remaining select values are unmapped
	localparam sel_t SEL_TIMER = 2'd0;
	localparam sel_t SEL_UART = 2'd1;

endpackage

// File: common/soc_periph_pkg.sv
// register offsets and bit positions of the timer and UART transmitter
package soc_periph_pkg;

	// --------------------
	// machine timer

	localparam soc_bus_pkg::pofs_t TMR_CTRL = 'h00;
	localparam soc_bus_pkg::pofs_t TMR_MTIME = 'h08;
	localparam soc_bus_pkg::pofs_t TMR_MTIMEH = 'h0c;
	localparam soc_bus_pkg::pofs_t TMR_MTIMECMP = 'h10;
	localparam soc_bus_pkg::pofs_t TMR_MTIMECMPH = 'h14;

	// ctrl bits
	localparam int TMR_CTRL_EN = 0;

	// --------------------
	// uart transmitter

	// character in the low 8 bits
	localparam soc_bus_pkg::pofs_t UART_TXDATA = 'h00;
	localparam soc_bus_pkg::pofs_t UART_STATUS = 'h04;

	// status bits
	localparam int UART_STATUS_BUSY = 0;

	typedef logic [7:0] byte_t;

endpackage

// File: hw/apb_splitter.sv
// APB decoder for two slaves with response merge and unmapped error reply
`timescale 1ns/10ps

module apb_splitter (
	input  logic     clk,
	input  logic     rst_n,
	apb_if.completer up,
	apb_if.requester tmr,
	apb_if.requester uart
);

	soc_bus_pkg::sel_t sel;

	assign sel = up.paddr[soc_bus_pkg::SEL_MSB:soc_bus_pkg::SEL_LSB];

	// --------------------
	// request side

	// psel only reaches the addressed slave
	assign tmr.psel = up.psel && (sel == soc_bus_pkg::SEL_TIMER);
	assign uart.psel = up.psel && (sel == soc_bus_pkg::SEL_UART);

	assign tmr.penable = up.penable;
	assign tmr.pwrite = up.pwrite;
	assign tmr.paddr = up.paddr;
	assign tmr.pwdata = up.pwdata;

	assign uart.penable = up.penable;
	assign uart.pwrite = up.pwrite;
	assign uart.paddr = up.paddr;
	assign uart.pwdata = up.pwdata;

	// --------------------
	// response side

	// paddr is held through the access, so the live select steers the mux
	always_comb begin
		case (sel)
			soc_bus_pkg::SEL_TIMER: begin
				up.prdata = tmr.prdata;
				up.pready = tmr.pready;
				up.pslverr = tmr.pslverr;
			end
			soc_bus_pkg::SEL_UART: begin
				up.prdata = uart.prdata;
				up.pready = uart.pready;
				up.pslverr = uart.pslverr;
			end
			default: begin
				// unmapped, answer here in the first access cycle
				up.prdata = '0;
				up.pready = 1'b1;
				up.pslverr = up.psel && up.penable;
			end
		endcase
	end

endmodule

// File: hw/periph_top.sv
// peripheral top level with APB decoder, machine timer and UART transmitter
`timescale 1ns/10ps

module periph_top #(
	parameter int CLK_MHZ = 4,
	parameter int UART_DIV = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  soc_bus_pkg::paddr_t paddr,
	input  soc_bus_pkg::pdata_t pwdata,
	output soc_bus_pkg::pdata_t prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic                dbg_halt,
	output logic                timer_irq,
	output logic                uart_tx
);

	apb_if up_bus ();
	apb_if tmr_bus ();
	apb_if uart_bus ();

	// --------------------
	// upstream port

	assign up_bus.psel = psel;
	assign up_bus.penable = penable;
	assign up_bus.pwrite = pwrite;
	assign up_bus.paddr = paddr;
	assign up_bus.pwdata = pwdata;

	assign prdata = up_bus.prdata;
	assign pready = up_bus.pready;
	assign pslverr = up_bus.pslverr;

	// --------------------
	// decoder and slaves

	apb_splitter splitter_u (
		.clk   (clk),
		.rst_n (rst_n),
		.up    (up_bus),
		.tmr   (tmr_bus),
		.uart  (uart_bus)
	);

	riscv_timer #(
		.CLK_MHZ (CLK_MHZ)
	) timer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb       (tmr_bus),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_tx_apb #(
		.UART_DIV (UART_DIV)
	) uart_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb     (uart_bus),
		.uart_tx (uart_tx)
	);

endmodule

// File: tb.f
common/soc_bus_pkg.sv
common/soc_periph_pkg.sv
common/apb_if.sv
hw/apb_splitter.sv
timer/riscv_timer.sv
uart/uart_tx_apb.sv
hw/periph_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: tb/tb_checker.sv
// testbench checker with reference read model, bus response checks, UART decoder and counts
`timescale 1ns/10ps

module tb_checker #(
	parameter int CLK_MHZ = 4,
	parameter int UART_DIV = 8
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [15:0] paddr,
	input  logic [31:0] pwdata,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic        pslverr,
	input  logic        dbg_halt,
	input  logic        timer_irq,
	input  logic        uart_tx,
	input  logic        seq_done,
	output int          checks,
	output int          errors
);

	localparam logic [13:0] OFS_CTRL = 14'h00;
	localparam logic [13:0] OFS_MTIME = 14'h08;
	localparam logic [13:0] OFS_CMP = 14'h10;
	localparam logic [13:0] OFS_CMPH = 14'h14;
	localparam logic [13:0] OFS_TXDATA = 14'h00;

	// record of completed writes
	logic        en_rec;
	logic [63:0] cmp_rec;
	logic [7:0]  tx_rec;
	logic        tx_valid;
	logic [7:0]  tx_queue[$];

	// mtime between two reads
	logic [31:0] prev_mtime;
	logic        have_prev;
	int          run_cycles;

	int check_count = 0;
	int err_count = 0;

	assign checks = check_count;
	assign errors = err_count;

	task automatic report_fail(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		err_count++;
	endtask

	// --------------------
	// reference model

	function automatic logic is_tracked(input logic [15:0] addr);
		if (addr[15:14] > 2'd1) begin
			return 1'b1;
		end
		if (addr[15:14] == 2'd0) begin
			return addr[13:0] == OFS_CTRL || addr[13:0] == OFS_CMP || addr[13:0] == OFS_CMPH;
		end
		return addr[13:0] == OFS_TXDATA && tx_valid;
	endfunction

	function automatic logic [31:0] expected_read(input logic [15:0] addr);
		if (addr[15:14] == 2'd0) begin
			case (addr[13:0])
				OFS_CTRL: return {31'd0, en_rec};
				OFS_CMP: return cmp_rec[31:0];
				OFS_CMPH: return cmp_rec[63:32];
				default: return 32'd0;
			endcase
		end else if (addr[15:14] == 2'd1 && addr[13:0] == OFS_TXDATA) begin
			return {24'd0, tx_rec};
		end
		// unmapped space reads zero
		return 32'd0;
	endfunction

	task automatic record_write(input logic [15:0] addr, input logic [31:0] data);
		if (addr[15:14] == 2'd0) begin
			case (addr[13:0])
				OFS_CTRL: en_rec = data[0];
				OFS_CMP: cmp_rec[31:0] = data;
				OFS_CMPH: cmp_rec[63:32] = data;
				default: ;
			endcase
		end else if (addr[15:14] == 2'd1 && addr[13:0] == OFS_TXDATA) begin
			tx_rec = data[7:0];
			tx_valid = 1'b1;
			tx_queue.push_back(data[7:0]);
		end
	endtask

	// mtime against elapsed running cycles, irq against the recorded compare value
	task automatic check_mtime(input logic [31:0] value);
		int exp_ticks;
		int diff;
		if (have_prev) begin
			check_count++;
			exp_ticks = run_cycles / CLK_MHZ;
			diff = int'(value - prev_mtime);
			if (run_cycles == 0 && value != prev_mtime) begin
				report_fail($sformatf("mtime moved from %0d to %0d while frozen",
					prev_mtime, value));
			end else if (value < prev_mtime) begin
				report_fail($sformatf("mtime went back from %0d to %0d", prev_mtime, value));
			end else if (diff > exp_ticks + 1 || diff + 1 < exp_ticks) begin
				report_fail($sformatf("mtime advanced %0d, expected %0d ticks", diff, exp_ticks));
			end
		end
		prev_mtime = value;
		have_prev = 1'b1;
		run_cycles = 0;
		check_count++;
		if (cmp_rec > {32'd0, value} && timer_irq !== 1'b0) begin
			report_fail($sformatf("timer_irq high with mtime %0d below mtimecmp", value));
		end else if (cmp_rec < {32'd0, value} && timer_irq !== 1'b1) begin
			report_fail($sformatf("timer_irq low with mtime %0d past mtimecmp", value));
		end
	endtask

	// --------------------
	// bus monitor

	always @(posedge clk) begin
		if (!rst_n) begin
			en_rec = 1'b0;
			cmp_rec = '1;
			tx_valid = 1'b0;
			tx_queue.delete();
			have_prev = 1'b0;
			run_cycles = 0;
		end else begin
			if (psel && penable) begin
				check_count++;
				if (pready !== 1'b1) begin
					$display("Error: transfer to 0x%04h not ready in its first access cycle", paddr);
					err_count++;
				end else if (pslverr !== (paddr[15:14] > 2'd1)) begin
					report_fail($sformatf("pslverr %b for address 0x%04h", pslverr, paddr));
				end else if (pwrite) begin
					record_write(paddr, pwdata);
				end else begin
					if (is_tracked(paddr) && prdata !== expected_read(paddr)) begin
						report_fail($sformatf("read 0x%04h gave 0x%08h, expected 0x%08h",
							paddr, prdata, expected_read(paddr)));
					end
					if (paddr[15:14] == 2'd0 && paddr[13:0] == OFS_MTIME) begin
						check_mtime(prdata);
					end
				end
			end
			if (en_rec && !dbg_halt) begin
				run_cycles++;
			end
		end
	end

	// --------------------
	// uart line decoder

	initial begin : uart_decoder
		logic [7:0] got;
		logic [7:0] exp;
		logic start_ok;
		logic stop_ok;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge uart_tx);
			@(posedge clk);
			// middle of the start bit
			repeat (UART_DIV / 2) @(posedge clk);
			start_ok = !uart_tx;
			for (int b = 0; b < 8; b++) begin
				repeat (UART_DIV) @(posedge clk);
				got[b] = uart_tx;
			end
			repeat (UART_DIV) @(posedge clk);
			stop_ok = uart_tx;
			check_count++;
			if (tx_queue.size() == 0) begin
				report_fail($sformatf("frame 0x%02h on uart_tx with no character written", got));
			end else begin
				exp = tx_queue.pop_front();
				if (!start_ok || !stop_ok || got !== exp) begin
					report_fail($sformatf("uart_tx sent 0x%02h (start %b stop %b), expected 0x%02h",
						got, start_ok, stop_ok, exp));
				end
			end
		end
	end

	always @(posedge seq_done) begin
		if (tx_queue.size() != 0) begin
			$display("Error: %0d written characters never appeared on uart_tx", tx_queue.size());
			err_count++;
		end
	end

endmodule

// File: tb/tb_top.sv
// testbench top with clock, reset, LCG, APB driver tasks, test sequence and watchdog
`timescale 1ns/10ps

module tb_top;

	localparam int CLK_MHZ = 4;
	localparam int UART_DIV = 8;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 16;
	localparam int N_CMP = 4;
	localparam int N_BYTES = 4;
	localparam int RUN_WAIT = 40;
	localparam int HALT_WAIT = 20;
	localparam int IRQ_WAIT = 8;

	// every transfer is one setup and one access cycle
	localparam int XFER = 2;
	localparam int SEQ_CYCLES = RESET_CYCLES + N_CMP * 4 * XFER + 4 * XFER
		+ RUN_WAIT + HALT_WAIT + IRQ_WAIT + 16 * XFER
		+ N_BYTES * (10 * UART_DIV + 4 * XFER) + 4 * UART_DIV;
	localparam int TIMEOUT_CYCLES = 2 * SEQ_CYCLES;

	localparam logic [15:0] A_CTRL = 16'h0000;
	localparam logic [15:0] A_MTIME = 16'h0008;
	localparam logic [15:0] A_CMP = 16'h0010;
	localparam logic [15:0] A_CMPH = 16'h0014;
	localparam logic [15:0] A_TXDATA = 16'h4000;
	localparam logic [15:0] A_STATUS = 16'h4004;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        dbg_halt;
	logic        timer_irq;
	logic        uart_tx;
	logic        seq_done;
	logic [31:0] seed;
	int          chk_checks;
	int          chk_errors;

	periph_top #(
		.CLK_MHZ  (CLK_MHZ),
		.UART_DIV (UART_DIV)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq),
		.uart_tx   (uart_tx)
	);

	tb_checker #(
		.CLK_MHZ  (CLK_MHZ),
		.UART_DIV (UART_DIV)
	) chk (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq),
		.uart_tx   (uart_tx),
		.seq_done  (seq_done),
		.checks    (chk_checks),
		.errors    (chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// --------------------
	// APB driver, entered and left just after a rising edge

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#(DRIVE_DELAY);
		penable = 1'b1;
		@(posedge clk);
		while (!pready) @(posedge clk);
		#(DRIVE_DELAY);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#(DRIVE_DELAY);
		penable = 1'b1;
		@(posedge clk);
		while (!pready) @(posedge clk);
		data = prdata;
		#(DRIVE_DELAY);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic wait_uart_idle();
		logic [31:0] status;
		apb_read(A_STATUS, status);
		while (status[0]) apb_read(A_STATUS, status);
	endtask

	// --------------------
	// test sequence

	initial begin : test_seq
		logic [31:0] data;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dbg_halt = 1'b0;
		seq_done = 1'b0;
		rst_n = 1'b0;
		seed = 32'h9072;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		idle_cycles(1);

		// mtimecmp halves
		for (int i = 0; i < N_CMP; i++) begin
			seed = lcg_next(seed);
			apb_write(A_CMP, seed);
			seed = lcg_next(seed);
			apb_write(A_CMPH, seed);
			apb_read(A_CMP, data);
			apb_read(A_CMPH, data);
		end

		// unmapped select values
		seed = lcg_next(seed);
		apb_write(16'h8000, seed);
		apb_read(16'h8004, data);
		apb_read(16'hc010, data);
		apb_write(16'hc008, seed);

		// running, then frozen by debug halt
		apb_write(A_CTRL, 32'd1);
		apb_read(A_CTRL, data);
		apb_read(A_MTIME, data);
		idle_cycles(RUN_WAIT);
		apb_read(A_MTIME, data);
		dbg_halt = 1'b1;
		idle_cycles(2);
		apb_read(A_MTIME, data);
		idle_cycles(HALT_WAIT);
		apb_read(A_MTIME, data);
		dbg_halt = 1'b0;

		// compare below mtime, then parked at all ones
		apb_write(A_CMPH, 32'd0);
		apb_write(A_CMP, 32'd2);
		idle_cycles(IRQ_WAIT);
		apb_read(A_MTIME, data);
		apb_write(A_CMP, '1);
		apb_write(A_CMPH, '1);
		apb_read(A_MTIME, data);

		for (int i = 0; i < N_BYTES; i++) begin
			wait_uart_idle();
			seed = lcg_next(seed);
			apb_write(A_TXDATA, {24'd0, seed[15:8]});
			apb_read(A_TXDATA, data);
		end
		wait_uart_idle();
		idle_cycles(2 * UART_DIV);

		seq_done = 1'b1;
		idle_cycles(1);
		$display("checks %0d, errors %0d", chk_checks, chk_errors);
		if (chk_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

// File: timer/riscv_timer.sv
// RISC-V machine timer with microsecond tick, mtime/mtimecmp, APB slave and irq
`timescale 1ns/10ps

module riscv_timer #(
	parameter int CLK_MHZ = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	apb_if.completer apb,
	input  logic     dbg_halt,
	output logic     timer_irq
);

	localparam int TICK_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	logic [TICK_W-1:0] tick_ctr;
	logic tick;
	logic enable;
	logic [63:0] mtime;
	logic [63:0] mtimecmp;
	soc_bus_pkg::pofs_t ofs;
	logic wr;

	assign ofs = apb.paddr[soc_bus_pkg::OFS_W-1:0];
	assign wr = apb.psel && apb.penable && apb.pwrite;

	// --------------------
	// microsecond tick

	// one tick every CLK_MHZ cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
			tick <= 1'b0;
		end else begin
			if (tick_ctr != '0) begin
				tick_ctr <= tick_ctr - 1'b1;
			end else begin
				tick_ctr <= TICK_W'(CLK_MHZ - 1);
			end
			tick <= (tick_ctr == '0);
		end
	end

	// --------------------
	// registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable <= 1'b0;
			mtime <= '0;
			mtimecmp <= '1;
		end else begin
			if (wr && ofs == soc_periph_pkg::TMR_CTRL) begin
				enable <= apb.pwdata[soc_periph_pkg::TMR_CTRL_EN];
			end
			// a bus write wins over the count for that cycle
			if (wr && ofs == soc_periph_pkg::TMR_MTIME) begin
				mtime[31:0] <= apb.pwdata;
			end else if (wr && ofs == soc_periph_pkg::TMR_MTIMEH) begin
				mtime[63:32] <= apb.pwdata;
			end else if (tick && enable && !dbg_halt) begin
				// frozen while the hart sits in debug
				mtime <= mtime + 64'd1;
			end
			if (wr && ofs == soc_periph_pkg::TMR_MTIMECMP) begin
				mtimecmp[31:0] <= apb.pwdata;
			end
			if (wr && ofs == soc_periph_pkg::TMR_MTIMECMPH) begin
				mtimecmp[63:32] <= apb.pwdata;
			end
		end
	end

	// registered compare
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// read mux, unknown offsets read zero
	always_comb begin
		apb.prdata = '0;
		case (ofs)
			soc_periph_pkg::TMR_CTRL: apb.prdata[soc_periph_pkg::TMR_CTRL_EN] = enable;
			soc_periph_pkg::TMR_MTIME: apb.prdata = mtime[31:0];
			soc_periph_pkg::TMR_MTIMEH: apb.prdata = mtime[63:32];
			soc_periph_pkg::TMR_MTIMECMP: apb.prdata = mtimecmp[31:0];
			soc_periph_pkg::TMR_MTIMECMPH: apb.prdata = mtimecmp[63:32];
			default: apb.prdata = '0;
		endcase
	end

	// no wait states
	assign apb.pready = 1'b1;
	assign apb.pslverr = 1'b0;

endmodule

// File: uart/uart_tx_apb.sv
// UART transmitter with APB data and status registers and a frame serialiser
`timescale 1ns/10ps

module uart_tx_apb #(
	parameter int UART_DIV = 8
) (
	input  logic     clk,
	input  logic     rst_n,
	apb_if.completer apb,
	output logic     uart_tx
);

	localparam int DIV_W = (UART_DIV > 1) ? $clog2(UART_DIV) : 1;
	// start, 8 data, stop
	localparam logic [3:0] LAST_BIT = 4'd9;

	soc_bus_pkg::pofs_t ofs;
	soc_periph_pkg::byte_t wr_byte;
	soc_periph_pkg::byte_t tx_data;
	logic wr;
	logic start;
	logic busy;
	logic [DIV_W-1:0] div_ctr;
	logic [3:0] bit_ctr;
	logic [9:0] shift;

	assign ofs = apb.paddr[soc_bus_pkg::OFS_W-1:0];
	assign wr = apb.psel && apb.penable && apb.pwrite;
	assign wr_byte = apb.pwdata[7:0];

	// writes while busy are dropped
	assign start = wr && (ofs == soc_periph_pkg::UART_TXDATA) && !busy;

	// --------------------
	// serialiser

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			div_ctr <= '0;
			bit_ctr <= '0;
			shift <= '1;
		end else if (start) begin
			busy <= 1'b1;
			div_ctr <= DIV_W'(UART_DIV - 1);
			bit_ctr <= LAST_BIT;
			shift <= {1'b1, wr_byte, 1'b0};
		end else if (busy) begin
			if (div_ctr != '0) begin
				div_ctr <= div_ctr - 1'b1;
			end else begin
				// end of a bit period, shift in idle level
				div_ctr <= DIV_W'(UART_DIV - 1);
				shift <= {1'b1, shift[9:1]};
				if (bit_ctr == '0) begin
					busy <= 1'b0;
				end else begin
					bit_ctr <= bit_ctr - 1'b1;
				end
			end
		end
	end

	assign uart_tx = shift[0];

	// last accepted character, for readback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_data <= '0;
		end else if (start) begin
			tx_data <= wr_byte;
		end
	end

	always_comb begin
		apb.prdata = '0;
		case (ofs)
			soc_periph_pkg::UART_TXDATA: apb.prdata[7:0] = tx_data;
			soc_periph_pkg::UART_STATUS: apb.prdata[soc_periph_pkg::UART_STATUS_BUSY] = busy;
			default: apb.prdata = '0;
		endcase
	end

	assign apb.pready = 1'b1;
	assign apb.pslverr = 1'b0;

endmodule
